//--- panel_pkg.sv
`default_nettype none

package panel_pkg;

    localparam int PIXEL_WIDTH = 64;
    localparam int PIXEL_HEIGHT = 32;
    localparam int PIXEL_COUNT = PIXEL_WIDTH * PIXEL_HEIGHT;

    typedef logic [$clog2(PIXEL_WIDTH)-1:0] column_t;
    typedef logic [$clog2(PIXEL_HEIGHT)-1:0] row_t;
    // one extra bit so a full-panel span fits.
    typedef logic [$clog2(PIXEL_WIDTH):0] col_span_t;
    typedef logic [$clog2(PIXEL_HEIGHT):0] row_span_t;
    // row in the upper bits, column in the lower bits.
    typedef logic [$clog2(PIXEL_COUNT)-1:0] pixel_addr_t;
    // rgb565.
    typedef logic [15:0] color_t;
    typedef logic [7:0] cmd_byte_t;

    typedef logic [11:0] wb_addr_t;
    typedef logic [15:0] wb_data_t;

    localparam cmd_byte_t CMD_FILLRECT = 8'h01;
    localparam cmd_byte_t CMD_BLANK = 8'h02;

    // address bit 11 selects a pixel read.
    localparam int PIXEL_SEL_BIT = 11;
    localparam wb_addr_t REG_CMD = 12'h000;
    localparam int STATUS_BUSY_BIT = 0;

endpackage

`default_nettype wire

//--- frame_buffer.sv
`default_nettype none

module frame_buffer (
    input  wire logic                   clk,
    input  wire logic                   wr_en,
    input  wire panel_pkg::pixel_addr_t wr_addr,
    input  wire panel_pkg::color_t      wr_color,
    input  wire panel_pkg::pixel_addr_t rd_addr,
    output panel_pkg::color_t           rd_color
);

    panel_pkg::color_t mem [panel_pkg::PIXEL_COUNT];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_color;
        end
    end

    // registered read, one cycle of latency.
    always_ff @(posedge clk) begin
        rd_color <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- fill_area_walker.sv
`default_nettype none

module fill_area_walker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   fill_start,
    input  wire panel_pkg::column_t     fill_x1,
    input  wire panel_pkg::row_t        fill_y1,
    input  wire panel_pkg::col_span_t   fill_width,
    input  wire panel_pkg::row_span_t   fill_height,
    input  wire panel_pkg::color_t      fill_color,
    output logic                        fill_done,
    output logic                        wr_en,
    output panel_pkg::pixel_addr_t      wr_addr,
    output panel_pkg::color_t           wr_color
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_WALK,
        W_EMPTY
    } walk_state_t;

    walk_state_t state;

    panel_pkg::column_t col;
    panel_pkg::column_t x_start;
    panel_pkg::row_t row;
    panel_pkg::col_span_t x_end;
    panel_pkg::col_span_t x_end_c;
    panel_pkg::row_span_t y_end;
    panel_pkg::row_span_t y_end_c;
    logic empty_c;
    logic last_col;
    logic last_row;

    // clip the far edges to the panel.
    always_comb begin
        if (int'(fill_x1) + int'(fill_width) > panel_pkg::PIXEL_WIDTH) begin
            x_end_c = panel_pkg::col_span_t'(panel_pkg::PIXEL_WIDTH);
        end else begin
            x_end_c = panel_pkg::col_span_t'(fill_x1) + fill_width;
        end
        if (int'(fill_y1) + int'(fill_height) > panel_pkg::PIXEL_HEIGHT) begin
            y_end_c = panel_pkg::row_span_t'(panel_pkg::PIXEL_HEIGHT);
        end else begin
            y_end_c = panel_pkg::row_span_t'(fill_y1) + fill_height;
        end
        empty_c = (fill_width == '0) || (fill_height == '0);
    end

    assign last_col = (panel_pkg::col_span_t'(col) + 1'b1) == x_end;
    assign last_row = (panel_pkg::row_span_t'(row) + 1'b1) == y_end;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= W_IDLE;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (fill_start) state <= empty_c ? W_EMPTY : W_WALK;
                end
                W_WALK: begin
                    if (last_col && last_row) begin
                        state <= W_IDLE;
                        fill_done <= 1'b1;
                    end
                end
                // nothing to draw, still report done.
                W_EMPTY: begin
                    state <= W_IDLE;
                    fill_done <= 1'b1;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_IDLE && fill_start) begin
            col <= fill_x1;
            row <= fill_y1;
            x_start <= fill_x1;
            x_end <= x_end_c;
            y_end <= y_end_c;
        end else if (state == W_WALK) begin
            if (last_col) begin
                col <= x_start;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign wr_en = (state == W_WALK);
    assign wr_addr = {row, col};
    assign wr_color = fill_color;

endmodule

`default_nettype wire

//--- cmd_sequencer.sv
`default_nettype none

module cmd_sequencer (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   cmd_valid,
    input  wire panel_pkg::cmd_byte_t   cmd_data,
    output logic                        ready_for_data,
    output logic                        busy,
    output logic                        fill_start,
    output panel_pkg::column_t          fill_x1,
    output panel_pkg::row_t             fill_y1,
    output panel_pkg::col_span_t        fill_width,
    output panel_pkg::row_span_t        fill_height,
    output panel_pkg::color_t           fill_color,
    input  wire logic                   fill_done
);

    typedef enum logic [3:0] {
        S_OPCODE,
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR_HI,
        S_COLOR_LO,
        S_START,
        S_RUNNING,
        S_DONE
    } seq_state_t;

    seq_state_t state;

    // parameter bytes as the host sent them.
    panel_pkg::cmd_byte_t x1_q;
    panel_pkg::cmd_byte_t y1_q;
    panel_pkg::cmd_byte_t width_q;
    panel_pkg::cmd_byte_t height_q;
    panel_pkg::color_t color_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_OPCODE;
            ready_for_data <= 1'b1;
            busy <= 1'b0;
            fill_start <= 1'b0;
        end else begin
            fill_start <= 1'b0;
            case (state)
                // done is a one-cycle wrap, and decodes like the opcode state.
                S_OPCODE, S_DONE: begin
                    state <= S_OPCODE;
                    if (cmd_valid) begin
                        if (cmd_data == panel_pkg::CMD_FILLRECT) begin
                            state <= S_X1;
                        end else if (cmd_data == panel_pkg::CMD_BLANK) begin
                            state <= S_START;
                            ready_for_data <= 1'b0;
                            busy <= 1'b1;
                        end
                    end
                end
                S_X1: begin
                    if (cmd_valid) state <= S_Y1;
                end
                S_Y1: begin
                    if (cmd_valid) state <= S_WIDTH;
                end
                S_WIDTH: begin
                    if (cmd_valid) state <= S_HEIGHT;
                end
                S_HEIGHT: begin
                    if (cmd_valid) state <= S_COLOR_HI;
                end
                S_COLOR_HI: begin
                    if (cmd_valid) state <= S_COLOR_LO;
                end
                S_COLOR_LO: begin
                    if (cmd_valid) begin
                        state <= S_START;
                        ready_for_data <= 1'b0;
                        busy <= 1'b1;
                    end
                end
                S_START: begin
                    fill_start <= 1'b1;
                    state <= S_RUNNING;
                end
                S_RUNNING: begin
                    if (fill_done) begin
                        busy <= 1'b0;
                        ready_for_data <= 1'b1;
                        state <= S_DONE;
                    end
                end
                default: state <= S_OPCODE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            case (state)
                S_OPCODE, S_DONE: begin
                    if (cmd_data == panel_pkg::CMD_BLANK) begin
                        x1_q <= '0;
                        y1_q <= '0;
                        width_q <= panel_pkg::cmd_byte_t'(panel_pkg::PIXEL_WIDTH);
                        height_q <= panel_pkg::cmd_byte_t'(panel_pkg::PIXEL_HEIGHT);
                        color_q <= '0;
                    end
                end
                S_X1: x1_q <= cmd_data;
                S_Y1: y1_q <= cmd_data;
                S_WIDTH: width_q <= cmd_data;
                S_HEIGHT: height_q <= cmd_data;
                S_COLOR_HI: color_q[15:8] <= cmd_data;
                S_COLOR_LO: color_q[7:0] <= cmd_data;
                default: ;
            endcase
        end
    end

    assign fill_x1 = panel_pkg::column_t'(x1_q);
    assign fill_y1 = panel_pkg::row_t'(y1_q);
    assign fill_color = color_q;

    // narrow to port width. an off-panel origin becomes an empty span.
    always_comb begin
        if (x1_q >= panel_pkg::PIXEL_WIDTH) begin
            fill_width = '0;
        end else if (width_q > panel_pkg::PIXEL_WIDTH) begin
            fill_width = panel_pkg::col_span_t'(panel_pkg::PIXEL_WIDTH);
        end else begin
            fill_width = panel_pkg::col_span_t'(width_q);
        end
        if (y1_q >= panel_pkg::PIXEL_HEIGHT) begin
            fill_height = '0;
        end else if (height_q > panel_pkg::PIXEL_HEIGHT) begin
            fill_height = panel_pkg::row_span_t'(panel_pkg::PIXEL_HEIGHT);
        end else begin
            fill_height = panel_pkg::row_span_t'(height_q);
        end
    end

endmodule

`default_nettype wire

//--- wb_cmd_port.sv
`default_nettype none

module wb_cmd_port (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire panel_pkg::wb_addr_t    wb_adr,
    input  wire panel_pkg::wb_data_t    wb_dat_w,
    output panel_pkg::wb_data_t         wb_dat_r,
    output logic                        wb_ack,
    input  wire logic                   ready_for_data,
    input  wire logic                   busy,
    output logic                        cmd_valid,
    output panel_pkg::cmd_byte_t        cmd_data,
    output panel_pkg::pixel_addr_t      rd_addr,
    input  wire panel_pkg::color_t      rd_color
);

    logic access;
    logic cmd_write;
    logic go;
    logic wait_state;

    // a new access, not the cycle that is already being acked.
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign cmd_write = wb_we && (wb_adr == panel_pkg::REG_CMD);
    // command writes stall until the sequencer can take a byte.
    assign go = !cmd_write || ready_for_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_state <= 1'b0;
            wb_ack <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            cmd_valid <= 1'b0;
            if (!access) begin
                wait_state <= 1'b0;
            end else if (go) begin
                if (wait_state) begin
                    wait_state <= 1'b0;
                    wb_ack <= 1'b1;
                    cmd_valid <= cmd_write;
                end else begin
                    wait_state <= 1'b1;
                end
            end
        end
    end

    // byte handed over together with the ack.
    always_ff @(posedge clk) begin
        if (access && go && wait_state) begin
            cmd_data <= wb_dat_w[7:0];
        end
    end

    // memory sees the address through the wait state.
    assign rd_addr = wb_adr[$bits(panel_pkg::pixel_addr_t)-1:0];

    always_comb begin
        wb_dat_r = '0;
        if (wb_adr[panel_pkg::PIXEL_SEL_BIT]) begin
            wb_dat_r = rd_color;
        end else if (wb_adr == panel_pkg::REG_CMD) begin
            wb_dat_r[panel_pkg::STATUS_BUSY_BIT] = busy;
        end
    end

endmodule

`default_nettype wire

//--- panel_cmd_top.sv
`default_nettype none

module panel_cmd_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire panel_pkg::wb_addr_t    wb_adr,
    input  wire panel_pkg::wb_data_t    wb_dat_w,
    output panel_pkg::wb_data_t         wb_dat_r,
    output logic                        wb_ack
);

    logic ready_for_data;
    logic busy;
    logic cmd_valid;
    panel_pkg::cmd_byte_t cmd_data;

    logic fill_start;
    logic fill_done;
    panel_pkg::column_t fill_x1;
    panel_pkg::row_t fill_y1;
    panel_pkg::col_span_t fill_width;
    panel_pkg::row_span_t fill_height;
    panel_pkg::color_t fill_color;

    logic wr_en;
    panel_pkg::pixel_addr_t wr_addr;
    panel_pkg::color_t wr_color;
    panel_pkg::pixel_addr_t rd_addr;
    panel_pkg::color_t rd_color;

    wb_cmd_port u_port (
        .clk            (clk),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .ready_for_data (ready_for_data),
        .busy           (busy),
        .cmd_valid      (cmd_valid),
        .cmd_data       (cmd_data),
        .rd_addr        (rd_addr),
        .rd_color       (rd_color)
    );

    cmd_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_data       (cmd_data),
        .ready_for_data (ready_for_data),
        .busy           (busy),
        .fill_start     (fill_start),
        .fill_x1        (fill_x1),
        .fill_y1        (fill_y1),
        .fill_width     (fill_width),
        .fill_height    (fill_height),
        .fill_color     (fill_color),
        .fill_done      (fill_done)
    );

    fill_area_walker u_walker (
        .clk            (clk),
        .reset          (reset),
        .fill_start     (fill_start),
        .fill_x1        (fill_x1),
        .fill_y1        (fill_y1),
        .fill_width     (fill_width),
        .fill_height    (fill_height),
        .fill_color     (fill_color),
        .fill_done      (fill_done),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_color       (wr_color)
    );

    frame_buffer u_fb (
        .clk            (clk),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_color       (wr_color),
        .rd_addr        (rd_addr),
        .rd_color       (rd_color)
    );

endmodule

`default_nettype wire

//--- panel_cmd_assert.sv
`default_nettype none

module panel_cmd_assert (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    wb_cyc,
    input wire logic                    wb_stb,
    input wire logic                    wb_ack,
    input wire logic                    wr_en,
    input wire panel_pkg::pixel_addr_t  wr_addr,
    input wire panel_pkg::column_t      fill_x1,
    input wire panel_pkg::row_t         fill_y1,
    input wire panel_pkg::col_span_t    fill_width,
    input wire panel_pkg::row_span_t    fill_height,
    input wire logic                    fill_start,
    input wire logic                    fill_done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic walker_busy;
    panel_pkg::column_t wr_col;
    panel_pkg::row_t wr_row;

    // walker owns the area from start until done.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            walker_busy <= 1'b0;
        end else if (fill_start) begin
            walker_busy <= 1'b1;
        end else if (fill_done) begin
            walker_busy <= 1'b0;
        end
    end

    // row in the upper bits, column in the lower bits.
    assign {wr_row, wr_col} = wr_addr;

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an active bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");

    // a wrapped column or row falls below the origin.
    write_in_area: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (!$isunknown(wr_addr)
            && (wr_col >= fill_x1)
            && (int'(wr_col) < int'(fill_x1) + int'(fill_width))
            && (wr_row >= fill_y1)
            && (int'(wr_row) < int'(fill_y1) + int'(fill_height))))
        else $error("pixel write outside the commanded area");

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        fill_start |-> !walker_busy)
        else $error("fill_start while the walker is busy");

endmodule

bind panel_cmd_top panel_cmd_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .fill_x1     (fill_x1),
    .fill_y1     (fill_y1),
    .fill_width  (fill_width),
    .fill_height (fill_height),
    .fill_start  (fill_start),
    .fill_done   (fill_done)
);

`default_nettype wire

//--- tb_panel_cmd.sv
`default_nettype none

module tb_panel_cmd;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_ROWS = 10;
    localparam int RANDOM_PROBES = 24;
    localparam int PROBES_PER_ROW = 8 + RANDOM_PROBES;
    localparam int W = panel_pkg::PIXEL_WIDTH;
    localparam int H = panel_pkg::PIXEL_HEIGHT;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    panel_pkg::wb_addr_t wb_adr;
    panel_pkg::wb_data_t wb_dat_w;
    panel_pkg::wb_data_t wb_dat_r;
    logic wb_ack;

    // per row: opcode, x1, y1, width, height, color hi, color lo.
    panel_pkg::cmd_byte_t tbl_bytes [NUM_ROWS][7];
    int tbl_count [NUM_ROWS];
    bit tbl_probe [NUM_ROWS];
    bit table_loaded;

    panel_pkg::color_t ref_pix [W][H];
    int error_count;
    integer seed;

    panel_cmd_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input int r, input panel_pkg::cmd_byte_t op, input int x1,
                           input int y1, input int w, input int h,
                           input panel_pkg::color_t color, input int count, input bit probe);
        tbl_bytes[r][0] = op;
        tbl_bytes[r][1] = 8'(x1);
        tbl_bytes[r][2] = 8'(y1);
        tbl_bytes[r][3] = 8'(w);
        tbl_bytes[r][4] = 8'(h);
        tbl_bytes[r][5] = color[15:8];
        tbl_bytes[r][6] = color[7:0];
        tbl_count[r] = count;
        tbl_probe[r] = probe;
    endtask

    task automatic load_table();
        add_row(0, panel_pkg::CMD_BLANK, 0, 0, 0, 0, 16'h0000, 1, 1'b1);
        add_row(1, panel_pkg::CMD_FILLRECT, 10, 5, 8, 6, 16'hf800, 7, 1'b1);
        // runs past the right and bottom edges.
        add_row(2, panel_pkg::CMD_FILLRECT, 60, 28, 10, 10, 16'h07e0, 7, 1'b1);
        add_row(3, panel_pkg::CMD_FILLRECT, 20, 10, 0, 4, 16'h1234, 7, 1'b1);
        add_row(4, panel_pkg::CMD_FILLRECT, 3, 3, 5, 0, 16'habcd, 7, 1'b1);
        add_row(5, panel_pkg::CMD_FILLRECT, 70, 2, 5, 5, 16'h5555, 7, 1'b1);
        // no poll after these two, so the following bytes meet a busy engine.
        add_row(6, panel_pkg::CMD_FILLRECT, 0, 0, 40, 20, 16'h001f, 7, 1'b0);
        add_row(7, 8'h7f, 0, 0, 0, 0, 16'h0000, 1, 1'b0);
        add_row(8, panel_pkg::CMD_FILLRECT, 30, 12, 20, 10, 16'hffff, 7, 1'b1);
        add_row(9, panel_pkg::CMD_FILLRECT, 35, 15, 10, 10, 16'h8421, 7, 1'b1);
    endtask

    function automatic int clip_end(input int start, input int span, input int limit);
        if (start + span > limit) begin
            return limit;
        end
        return start + span;
    endfunction

    function automatic void get_rect(input int r, output int x1, output int y1,
                                     output int w, output int h);
        x1 = 0;
        y1 = 0;
        w = 0;
        h = 0;
        if (tbl_bytes[r][0] == panel_pkg::CMD_BLANK) begin
            w = W;
            h = H;
        end else if (tbl_bytes[r][0] == panel_pkg::CMD_FILLRECT) begin
            x1 = int'(tbl_bytes[r][1]);
            y1 = int'(tbl_bytes[r][2]);
            w = int'(tbl_bytes[r][3]);
            h = int'(tbl_bytes[r][4]);
        end
    endfunction

    function automatic int pixel_budget();
        int total;
        int x1;
        int y1;
        int w;
        int h;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            get_rect(r, x1, y1, w, h);
            total += w * h;
            if (tbl_probe[r]) begin
                total += PROBES_PER_ROW;
            end
        end
        return total;
    endfunction

    task automatic update_model(input int r);
        int x1;
        int y1;
        int w;
        int h;
        int xe;
        int ye;
        panel_pkg::color_t color;
        get_rect(r, x1, y1, w, h);
        color = (tbl_bytes[r][0] == panel_pkg::CMD_FILLRECT) ?
            {tbl_bytes[r][5], tbl_bytes[r][6]} : 16'h0000;
        xe = clip_end(x1, w, W);
        ye = clip_end(y1, h, H);
        for (int y = y1; y < ye; y++) begin
            for (int x = x1; x < xe; x++) begin
                ref_pix[x][y] = color;
            end
        end
    endtask

    task automatic wait_ack();
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input panel_pkg::wb_addr_t adr, input panel_pkg::wb_data_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic bus_read(input panel_pkg::wb_addr_t adr, output panel_pkg::wb_data_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_idle();
        panel_pkg::wb_data_t status;
        bus_read(panel_pkg::REG_CMD, status);
        while (status[panel_pkg::STATUS_BUSY_BIT]) begin
            bus_read(panel_pkg::REG_CMD, status);
        end
        check_value("wb_dat_r status", 16'h0000, status);
    endtask

    task automatic check_pixel(input int x, input int y);
        panel_pkg::wb_data_t data;
        bus_read({1'b1, 5'(y), 6'(x)}, data);
        check_value($sformatf("wb_dat_r pixel x=%0d y=%0d", x, y), ref_pix[x][y], data);
    endtask

    task automatic probe_row(input int r);
        int x1;
        int y1;
        int w;
        int h;
        int xe;
        int ye;
        int rnd;
        int px [8];
        int py [8];
        get_rect(r, x1, y1, w, h);
        xe = clip_end(x1, w, W);
        ye = clip_end(y1, h, H);
        // corners, then the pixels diagonally outside them.
        px = '{x1, xe - 1, x1, xe - 1, x1 - 1, xe, x1 - 1, xe};
        py = '{y1, y1, ye - 1, ye - 1, y1 - 1, y1 - 1, ye, ye};
        for (int i = 0; i < 8; i++) begin
            // off-panel neighbors land on the opposite edge.
            check_pixel(px[i] & (W - 1), py[i] & (H - 1));
        end
        for (int i = 0; i < RANDOM_PROBES; i++) begin
            rnd = $random(seed);
            check_pixel(rnd & (W - 1), (rnd >> 6) & (H - 1));
        end
    endtask

    task automatic apply_row(input int r);
        for (int i = 0; i < tbl_count[r]; i++) begin
            bus_write(panel_pkg::REG_CMD, {8'h00, tbl_bytes[r][i]});
        end
        update_model(r);
    endtask

    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = 8 * pixel_budget();
        #(limit * CLK_PERIOD);
        $display("timeout: the command table did not finish within %0d clock periods", limit);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 81;
        error_count = 0;
        table_loaded = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        load_table();
        table_loaded = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("wb_ack", 16'h0000, {15'b0, wb_ack});
        wait_idle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
            if (tbl_probe[r]) begin
                wait_idle();
                probe_row(r);
            end
        end
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- panel_cmd_top.f
panel_pkg.sv
frame_buffer.sv
fill_area_walker.sv
cmd_sequencer.sv
wb_cmd_port.sv
panel_cmd_top.sv
panel_cmd_assert.sv
tb_panel_cmd.sv

//--- Bender.yml
package:
  name: panel_cmd

sources:
  - panel_pkg.sv
  - frame_buffer.sv
  - fill_area_walker.sv
  - cmd_sequencer.sv
  - wb_cmd_port.sv
  - panel_cmd_top.sv
  - target: test
    files:
      - panel_cmd_assert.sv
      - tb_panel_cmd.sv
